//--- verilog.f
hw/aes_pkg.sv
hw/aes_mmio_regs.sv
hw/aes_key_schedule.sv
hw/aes_round_engine.sv
hw/aes_ctr_top.sv
tests/aes_ctr_checker.sv
tests/aes_ctr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= aes_ctr_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/aes_ctr_tb.sv
module aes_ctr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import aes_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int POLL_LIMIT      = 40;

    // FIPS-197 appendix B ciphertext
    localparam logic [127:0] FIPS_B_OUT = 128'h3925841d02dc09fbdc118597196a0b32;

    logic         clk;
    logic         rst_n;
    mmio_req_t    bus_req;
    mmio_rsp_t    bus_rsp;
    logic         irq;
    logic [15:0]  lfsr_q;
    string        cur_test;
    int           test_errors;
    int           error_count;
    int           tests_run;
    int           tests_failed;
    int           irq_count = 0;
    logic [127:0] t2_din;

    aes_ctr_top i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .bus_i (bus_req),
        .bus_o (bus_rsp),
        .irq_o (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Interrupt pulses seen on the falling edge
    always @(negedge clk) begin
        if (irq) begin
            irq_count++;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[15:1]} ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < 128; i++) begin
            v = {v[126:0], next_rand_bit()};
        end
        return v;
    endfunction

    // ========================================
    // Bus access and check helpers
    // ========================================
    task automatic bus_cycle(input logic wen, input logic [6:0] addr,
                             input logic [31:0] wdata, output logic [63:0] rdata);
        @(negedge clk);
        bus_req.req   = 1'b1;
        bus_req.wen   = wen;
        bus_req.addr  = addr;
        bus_req.wdata = {32'h0, wdata};
        @(negedge clk);
        bus_req = '0;
        if (!bus_rsp.ack) begin
            $display("%s: no acknowledge for offset %h", cur_test, addr);
            test_errors++;
        end
        rdata = bus_rsp.rdata;
    endtask

    task automatic bus_write(input logic [6:0] addr, input logic [31:0] data);
        logic [63:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [6:0] addr, output logic [63:0] data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic check_equal(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic wait_status(input int bit_idx, input string what);
        logic [63:0] st;
        int          n;
        n = 0;
        do begin
            bus_read(OFS_STATUS, st);
            n++;
        end while (!st[bit_idx] && n < POLL_LIMIT);
        if (!st[bit_idx]) begin
            $display("%s: timed out waiting for %s", cur_test, what);
            test_errors++;
        end
    endtask

    task automatic load_key(input logic [127:0] key);
        bus_write(OFS_KEY0, key[127:96]);
        bus_write(OFS_KEY1, key[95:64]);
        bus_write(OFS_KEY2, key[63:32]);
        bus_write(OFS_KEY3, key[31:0]);
        bus_write(OFS_CMD, 32'h1);
        wait_status(ST_KEYS_READY, "keys_ready");
    endtask

    task automatic set_counter_block(input logic [95:0] iv, input logic [31:0] ctr);
        bus_write(OFS_IV0, iv[95:64]);
        bus_write(OFS_IV1, iv[63:32]);
        bus_write(OFS_IV2, iv[31:0]);
        bus_write(OFS_CTR, ctr);
    endtask

    // The last data word starts the block
    task automatic run_block(input logic [127:0] din);
        bus_write(OFS_DIN0, din[127:96]);
        bus_write(OFS_DIN1, din[95:64]);
        bus_write(OFS_DIN2, din[63:32]);
        bus_write(OFS_DIN3, din[31:0]);
        wait_status(ST_DONE, "done");
    endtask

    task automatic read_dout(output logic [127:0] v);
        logic [63:0] w;
        bus_read(OFS_DOUT0, w);
        v[127:96] = w[31:0];
        bus_read(OFS_DOUT1, w);
        v[95:64] = w[31:0];
        bus_read(OFS_DOUT2, w);
        v[63:32] = w[31:0];
        bus_read(OFS_DOUT3, w);
        v[31:0] = w[31:0];
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_reset();
        logic [63:0]  st;
        logic [127:0] dout;
        begin_test("reset_state");
        bus_read(OFS_STATUS, st);
        check_equal("status", 128'h0, {64'h0, st});
        read_dout(dout);
        check_equal("data_out", 128'h0, dout);
        check_equal("irq", 128'h0, {127'h0, irq});
        end_test();
    endtask

    task automatic test_fips_c1();
        logic [127:0] dout;
        logic [63:0]  ctr;
        int           irq_before;
        begin_test("fips_c1");
        load_key(128'h000102030405060708090a0b0c0d0e0f);
        set_counter_block(96'h00112233445566778899aabb, 32'hccddeeff);
        irq_before = irq_count;
        run_block(128'h0);
        read_dout(dout);
        check_equal("data_out", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, dout);
        check_equal("irq pulses", 128'd1, 128'(irq_count - irq_before));
        bus_read(OFS_CTR, ctr);
        check_equal("counter", 128'hccddef00, {64'h0, ctr});
        end_test();
    endtask

    task automatic test_fips_b();
        logic [127:0] dout;
        begin_test("fips_b");
        load_key(128'h2b7e151628aed2a6abf7158809cf4f3c);
        set_counter_block(96'h3243f6a8885a308d313198a2, 32'he0370734);
        t2_din = rand_block();
        run_block(t2_din);
        read_dout(dout);
        check_equal("data_out", t2_din ^ FIPS_B_OUT, dout);
        end_test();
    endtask

    task automatic test_counter_wrap();
        logic [63:0] ctr;
        begin_test("counter_wrap");
        bus_write(OFS_CTR, 32'hffffffff);
        run_block(t2_din);
        bus_read(OFS_CTR, ctr);
        check_equal("counter after ffffffff", 128'h0, {64'h0, ctr});
        run_block(t2_din);
        bus_read(OFS_CTR, ctr);
        check_equal("counter after 0", 128'h1, {64'h0, ctr});
        end_test();
    endtask

    task automatic test_ignored_trigger();
        logic [63:0]  st;
        logic [127:0] dout;
        int           irq_before;
        begin_test("ignored_trigger");
        irq_before = irq_count;
        bus_write(OFS_DIN0, t2_din[127:96]);
        bus_write(OFS_DIN1, t2_din[95:64]);
        bus_write(OFS_DIN2, t2_din[63:32]);
        // Trigger while the restarted key schedule runs
        bus_write(OFS_CMD, 32'h1);
        bus_write(OFS_DIN3, t2_din[31:0]);
        bus_read(OFS_STATUS, st);
        check_equal("status", 128'h0, {64'h0, st});
        wait_status(ST_KEYS_READY, "keys_ready");
        bus_write(OFS_CTR, 32'he0370734);
        run_block(t2_din);
        read_dout(dout);
        check_equal("data_out", t2_din ^ FIPS_B_OUT, dout);
        // Only the accepted block raises an interrupt
        check_equal("irq pulses", 128'd1, 128'(irq_count - irq_before));
        end_test();
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        bus_req      = '0;
        rst_n        = 1'b0;
        lfsr_q       = 16'd44933;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        t2_din       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_fips_c1();
        test_fips_b();
        test_counter_wrap();
        test_ignored_trigger();

        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, i_dut.i_checker.fail_count);
        if (error_count == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tests/aes_ctr_checker.sv
module aes_ctr_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  aes_pkg::mmio_req_t req_i,
    input  aes_pkg::mmio_rsp_t rsp_i,
    input  logic               irq_i,
    input  logic               done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // ========================================
    // Bus protocol
    // ========================================
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_i.req |=> rsp_i.ack)
    else begin
        fail_count++;
        $error("request without acknowledge on the next cycle");
    end

    ack_only_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        !req_i.req |=> !rsp_i.ack)
    else begin
        fail_count++;
        $error("acknowledge without a request");
    end

    // ========================================
    // Interrupt
    // ========================================
    irq_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        irq_i |=> !irq_i)
    else begin
        fail_count++;
        $error("interrupt high for more than one cycle");
    end

    irq_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        irq_i |-> done_i)
    else begin
        fail_count++;
        $error("interrupt raised while done is clear");
    end

endmodule

bind aes_ctr_top aes_ctr_checker i_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (bus_i),
    .rsp_i  (bus_o),
    .irq_i  (irq_o),
    .done_i (i_regs.done)
);

//--- hw/aes_ctr_top.sv
module aes_ctr_top (
    input  logic               clk,
    input  logic               rst_n,
    input  aes_pkg::mmio_req_t bus_i,
    output aes_pkg::mmio_rsp_t bus_o,
    output logic               irq_o
);
    import aes_pkg::*;

    ks_cmd_t  ks_cmd;
    logic     keys_ready;
    rk_idx_t  rk_idx;
    blk_t     rk;
    blk_req_t blk_req;
    blk_res_t blk_res;

    // Bus front end, counter and status
    aes_mmio_regs i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_i        (bus_i),
        .bus_o        (bus_o),
        .keys_ready_i (keys_ready),
        .res_i        (blk_res),
        .ks_cmd_o     (ks_cmd),
        .blk_req_o    (blk_req),
        .irq_o        (irq_o)
    );

    aes_key_schedule i_ks (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_i        (ks_cmd),
        .rk_idx_i     (rk_idx),
        .rk_o         (rk),
        .keys_ready_o (keys_ready)
    );

    // One round per cycle on the counter block
    aes_round_engine i_eng (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (blk_req),
        .rk_i     (rk),
        .rk_idx_o (rk_idx),
        .res_o    (blk_res)
    );

endmodule

//--- hw/aes_round_engine.sv
module aes_round_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  aes_pkg::blk_req_t req_i,
    input  aes_pkg::blk_t     rk_i,
    output aes_pkg::rk_idx_t  rk_idx_o,
    output aes_pkg::blk_res_t res_o
);
    import aes_pkg::*;

    rk_idx_t rnd_q;
    blk_t    state_q;
    logic    valid_q;
    blk_t    sr_blk;
    blk_t    mc_blk;

    // SubBytes and ShiftRows shared by middle and final rounds
    assign sr_blk = shift_rows(sub_bytes(state_q));
    assign mc_blk = mix_columns(sr_blk);

    // Round index doubles as the key store address
    assign rk_idx_o    = rnd_q;
    assign res_o.valid = valid_q;
    assign res_o.blk   = state_q;

    // ========================================
    // Round sequencing
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (rnd_q == '0) begin
                if (req_i.start) begin
                    rnd_q <= rk_idx_t'(1);
                end
            end else if (rnd_q == rk_idx_t'(NUM_ROUNDS)) begin
                rnd_q   <= '0;
                valid_q <= 1'b1;
            end else begin
                rnd_q <= rnd_q + 1'b1;
            end
        end
    end

    // State register
    always_ff @(posedge clk) begin
        if (rnd_q == '0) begin
            // Initial AddRoundKey with round key 0
            if (req_i.start) begin
                state_q <= req_i.blk ^ rk_i;
            end
        end else if (rnd_q == rk_idx_t'(NUM_ROUNDS)) begin
            // Last round skips MixColumns
            state_q <= sr_blk ^ rk_i;
        end else begin
            state_q <= mc_blk ^ rk_i;
        end
    end

endmodule

//--- hw/aes_key_schedule.sv
module aes_key_schedule (
    input  logic             clk,
    input  logic             rst_n,
    input  aes_pkg::ks_cmd_t cmd_i,
    input  aes_pkg::rk_idx_t rk_idx_i,
    output aes_pkg::blk_t    rk_o,
    output logic             keys_ready_o
);
    import aes_pkg::*;

    blk_t              rk_mem [0:NUM_ROUNDS];
    logic [BLK_W-1:0]  last_q;
    rk_idx_t           cnt_q;
    logic [7:0]        rcon_q;
    logic [WORD_W-1:0] w0;
    logic [WORD_W-1:0] w1;
    logic [WORD_W-1:0] w2;
    logic [WORD_W-1:0] w3;
    logic [WORD_W-1:0] rot_w;
    logic [WORD_W-1:0] temp;
    logic [BLK_W-1:0]  next_key;

    // ========================================
    // One AES-128 expansion step
    // ========================================
    assign {w0, w1, w2, w3} = last_q;
    assign rot_w = {w3[23:0], w3[31:24]};
    assign temp  = {sbox(rot_w[31:24]), sbox(rot_w[23:16]),
                    sbox(rot_w[15:8]), sbox(rot_w[7:0])} ^ {rcon_q, 24'h0};

    // XOR chain across the four words
    assign next_key[127:96] = w0 ^ temp;
    assign next_key[95:64]  = w1 ^ next_key[127:96];
    assign next_key[63:32]  = w2 ^ next_key[95:64];
    assign next_key[31:0]   = w3 ^ next_key[63:32];

    // cnt_q is the index of the next round key and stays zero when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q        <= '0;
            rcon_q       <= '0;
            keys_ready_o <= 1'b0;
        end else if (cmd_i.start) begin
            cnt_q        <= rk_idx_t'(1);
            rcon_q       <= 8'h01;
            keys_ready_o <= 1'b0;
        end else if (cnt_q != '0) begin
            rcon_q <= xtime(rcon_q);
            if (cnt_q == rk_idx_t'(NUM_ROUNDS)) begin
                cnt_q        <= '0;
                keys_ready_o <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Round key store
    always_ff @(posedge clk) begin
        if (cmd_i.start) begin
            rk_mem[0] <= cmd_i.key;
            last_q    <= cmd_i.key;
        end else if (cnt_q != '0) begin
            rk_mem[cnt_q] <= next_key;
            last_q        <= next_key;
        end
    end

    assign rk_o = rk_mem[rk_idx_i];

endmodule

//--- hw/aes_mmio_regs.sv
module aes_mmio_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  aes_pkg::mmio_req_t bus_i,
    output aes_pkg::mmio_rsp_t bus_o,
    input  logic               keys_ready_i,
    input  aes_pkg::blk_res_t  res_i,
    output aes_pkg::ks_cmd_t   ks_cmd_o,
    output aes_pkg::blk_req_t  blk_req_o,
    output logic               irq_o
);
    import aes_pkg::*;

    logic [BLK_W-1:0]  key_q;
    logic [IV_W-1:0]   iv_q;
    logic [CTR_W-1:0]  ctr_q;
    logic [BLK_W-1:0]  din_q;
    logic [BLK_W-1:0]  dout_q;
    logic              busy;
    logic              done;
    logic              ks_start;
    logic              blk_start;
    logic              wr;
    logic              rd;
    logic              trigger;
    logic [WORD_W-1:0] wword;
    logic [DATA_W-1:0] status;
    logic [DATA_W-1:0] rd_mux;

    assign wr    = bus_i.req && bus_i.wen;
    assign rd    = bus_i.req && !bus_i.wen;
    assign wword = bus_i.wdata[WORD_W-1:0];

    // Last data word starts a block once keys are in place
    assign trigger = wr && (bus_i.addr == OFS_DIN3) && keys_ready_i && !busy && !ks_start;

    assign ks_cmd_o.start  = ks_start;
    assign ks_cmd_o.key    = key_q;
    assign blk_req_o.start = blk_start;
    assign blk_req_o.blk   = {iv_q, ctr_q};

    always_comb begin
        status                = '0;
        status[ST_BUSY]       = busy;
        status[ST_DONE]       = done;
        status[ST_KEYS_READY] = keys_ready_i;
    end

    always_comb begin
        case (bus_i.addr)
            OFS_STATUS: rd_mux = status;
            OFS_CTR:    rd_mux = DATA_W'(ctr_q);
            OFS_DOUT0:  rd_mux = DATA_W'(dout_q[127:96]);
            OFS_DOUT1:  rd_mux = DATA_W'(dout_q[95:64]);
            OFS_DOUT2:  rd_mux = DATA_W'(dout_q[63:32]);
            OFS_DOUT3:  rd_mux = DATA_W'(dout_q[31:0]);
            default:    rd_mux = '0;
        endcase
    end

    // ========================================
    // Register file and block control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q     <= '0;
            iv_q      <= '0;
            ctr_q     <= '0;
            din_q     <= '0;
            dout_q    <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            ks_start  <= 1'b0;
            blk_start <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            // Commands arriving mid-block are dropped
            ks_start  <= wr && (bus_i.addr == OFS_CMD) && !busy;
            blk_start <= trigger;
            irq_o     <= res_i.valid;

            // CTR output and counter step on each finished block
            if (res_i.valid) begin
                dout_q <= din_q ^ res_i.blk;
                ctr_q  <= ctr_q + CTR_W'(1);
                busy   <= 1'b0;
                done   <= 1'b1;
            end

            if (wr) begin
                case (bus_i.addr)
                    OFS_KEY0: key_q[127:96] <= wword;
                    OFS_KEY1: key_q[95:64]  <= wword;
                    OFS_KEY2: key_q[63:32]  <= wword;
                    OFS_KEY3: key_q[31:0]   <= wword;
                    OFS_IV0:  iv_q[95:64]   <= wword;
                    OFS_IV1:  iv_q[63:32]   <= wword;
                    OFS_IV2:  iv_q[31:0]    <= wword;
                    OFS_CTR:  ctr_q         <= wword;
                    OFS_CMD: begin
                        if (!busy) begin
                            done <= 1'b0;
                        end
                    end
                    OFS_DIN0: din_q[127:96] <= wword;
                    OFS_DIN1: din_q[95:64]  <= wword;
                    OFS_DIN2: din_q[63:32]  <= wword;
                    OFS_DIN3: din_q[31:0]   <= wword;
                    default: ;
                endcase
            end

            if (trigger) begin
                busy <= 1'b1;
                done <= 1'b0;
            end
        end
    end

    // Single-cycle acknowledge, reads return zero for writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_o <= '0;
        end else begin
            bus_o.ack   <= bus_i.req;
            bus_o.rdata <= rd ? rd_mux : '0;
        end
    end

endmodule

//--- hw/aes_pkg.sv
package aes_pkg;

    // ========================================
    // Widths and round count
    // ========================================
    localparam int BLK_W      = 128;
    localparam int IV_W       = 96;
    localparam int CTR_W      = 32;
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 7;
    localparam int DATA_W     = 64;
    localparam int NUM_ROUNDS = 10;

    // ========================================
    // Register map
    // ========================================
    // Key words, most significant first
    localparam logic [ADDR_W-1:0] OFS_KEY0   = 7'h00;
    localparam logic [ADDR_W-1:0] OFS_KEY1   = 7'h04;
    localparam logic [ADDR_W-1:0] OFS_KEY2   = 7'h08;
    localparam logic [ADDR_W-1:0] OFS_KEY3   = 7'h0C;
    localparam logic [ADDR_W-1:0] OFS_IV0    = 7'h20;
    localparam logic [ADDR_W-1:0] OFS_IV1    = 7'h24;
    localparam logic [ADDR_W-1:0] OFS_IV2    = 7'h28;
    localparam logic [ADDR_W-1:0] OFS_CTR    = 7'h2C;
    localparam logic [ADDR_W-1:0] OFS_CMD    = 7'h38;
    localparam logic [ADDR_W-1:0] OFS_STATUS = 7'h39;
    localparam logic [ADDR_W-1:0] OFS_DIN0   = 7'h40;
    localparam logic [ADDR_W-1:0] OFS_DIN1   = 7'h44;
    localparam logic [ADDR_W-1:0] OFS_DIN2   = 7'h48;
    localparam logic [ADDR_W-1:0] OFS_DIN3   = 7'h4C;
    localparam logic [ADDR_W-1:0] OFS_DOUT0  = 7'h50;
    localparam logic [ADDR_W-1:0] OFS_DOUT1  = 7'h54;
    localparam logic [ADDR_W-1:0] OFS_DOUT2  = 7'h58;
    localparam logic [ADDR_W-1:0] OFS_DOUT3  = 7'h5C;

    // Status bit positions
    localparam int ST_BUSY       = 0;
    localparam int ST_DONE       = 1;
    localparam int ST_KEYS_READY = 2;

    // ========================================
    // Types
    // ========================================
    // Byte 0 sits in the top bits, byte 4*col+row
    typedef logic [0:15][7:0] blk_t;
    typedef logic [3:0]       rk_idx_t;

    typedef struct packed {
        logic              req;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mmio_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } mmio_rsp_t;

    typedef struct packed {
        logic start;
        blk_t key;
    } ks_cmd_t;

    typedef struct packed {
        logic start;
        blk_t blk;
    } blk_req_t;

    typedef struct packed {
        logic valid;
        blk_t blk;
    } blk_res_t;

    // ========================================
    // Rijndael S-box, entry 0 leftmost
    // ========================================
    localparam logic [0:255][7:0] SBOX_TBL = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] x);
        return SBOX_TBL[x];
    endfunction

    // Multiply by 2 in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic blk_t sub_bytes(input blk_t s);
        blk_t r;
        for (int i = 0; i < 16; i++) begin
            r[i] = sbox(s[i]);
        end
        return r;
    endfunction

    // Row r rotates left by r columns
    function automatic blk_t shift_rows(input blk_t s);
        blk_t r;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                r[4*c + row] = s[4*((c + row) % 4) + row];
            end
        end
        return r;
    endfunction

    function automatic blk_t mix_columns(input blk_t s);
        blk_t       r;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++) begin
            a0 = s[4*c];
            a1 = s[4*c + 1];
            a2 = s[4*c + 2];
            a3 = s[4*c + 3];
            r[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            r[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            r[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            r[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return r;
    endfunction

endpackage
